// ==== hdl/cache_settings.svh ====
// Geometry of the two-way write-back cache.
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Width of a word address.
`define CACHE_ADDR_BITS 16

// Words per cache line.
`define CACHE_LINE_WORDS 4

// Sets per way.
`define CACHE_LINES 8

// Number of ways.
`define CACHE_WAYS 2

// Width of one data word.
`define CACHE_DATA_BITS 32

`endif

// ==== hdl/mem_bus_pkg.sv ====
// Address field and memory operation types shared by the cache and its buses.
`default_nettype none
`include "cache_settings.svh"

package mem_bus_pkg;

    // Field widths of a word address.
    localparam int OFFSET_BITS = $clog2(`CACHE_LINE_WORDS);
    localparam int INDEX_BITS  = $clog2(`CACHE_LINES);
    localparam int TAG_BITS    = `CACHE_ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef logic [`CACHE_ADDR_BITS-1:0]   word_addr_t;
    typedef logic [`CACHE_DATA_BITS-1:0]   word_t;
    typedef logic [`CACHE_DATA_BITS/8-1:0] byte_mask_t;
    typedef logic [OFFSET_BITS-1:0]        line_offset_t;
    typedef logic [INDEX_BITS-1:0]         set_index_t;
    typedef logic [TAG_BITS-1:0]           tag_t;

    // A word address split into its fields.
    typedef struct packed {
        tag_t         tag;
        set_index_t   set;
        line_offset_t offset;
    } addr_fields_t;

    // Word position inside the data store.
    typedef struct packed {
        set_index_t   set;
        line_offset_t offset;
    } line_addr_t;

    typedef enum logic [1:0] {MEM_IDLE, MEM_READ, MEM_WRITE} mem_op_t;

endpackage

`default_nettype wire

// ==== hdl/cache_pkg.sv ====
// Tag entry, way index and controller state types of the cache.
`default_nettype none
`include "cache_settings.svh"

package cache_pkg;

    localparam int WAY_BITS = $clog2(`CACHE_WAYS);

    typedef logic [WAY_BITS-1:0] way_t;

    // One way's tag with its state flags.
    typedef struct packed {
        logic              valid;
        logic              dirty;
        mem_bus_pkg::tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FLUSH_SCAN,
        ST_FLUSH_WB
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/cache_ifs.sv ====
// Controller-to-store interfaces for the tag RAM and the data RAM.
`timescale 1ns/1ns
`default_nettype none
`include "cache_settings.svh"

interface tag_if;
    // Driven by the controller.
    mem_bus_pkg::set_index_t index;
    mem_bus_pkg::tag_t       lookup_tag;
    logic                    wr_en;
    cache_pkg::way_t         wr_way;
    cache_pkg::tag_entry_t   wr_entry;
    logic                    advance_victim;

    // Returned by the store one cycle after index.
    logic                    hit;
    cache_pkg::way_t         hit_way;
    cache_pkg::way_t         victim_way;
    cache_pkg::tag_entry_t   victim_entry;
    cache_pkg::tag_entry_t   scan_entry;

    modport ctrl (
        output index, lookup_tag, wr_en, wr_way, wr_entry, advance_victim,
        input  hit, hit_way, victim_way, victim_entry, scan_entry
    );

    modport store (
        input  index, lookup_tag, wr_en, wr_way, wr_entry, advance_victim,
        output hit, hit_way, victim_way, victim_entry, scan_entry
    );
endinterface

interface data_if;
    // Driven by the controller.
    mem_bus_pkg::line_addr_t rd_addr;
    logic                    wr_en;
    cache_pkg::way_t         wr_way;
    mem_bus_pkg::line_addr_t wr_addr;
    mem_bus_pkg::byte_mask_t wr_mask;
    mem_bus_pkg::word_t      wr_data;

    // One word per way, one cycle after rd_addr.
    mem_bus_pkg::word_t [`CACHE_WAYS-1:0] way_data;

    modport ctrl (
        output rd_addr, wr_en, wr_way, wr_addr, wr_mask, wr_data,
        input  way_data
    );

    modport store (
        input  rd_addr, wr_en, wr_way, wr_addr, wr_mask, wr_data,
        output way_data
    );
endinterface

`default_nettype wire

// ==== hdl/tag_store.sv ====
// Tag RAM with round-robin victim pointers and a parallel compare in every way.
`timescale 1ns/1ns
`default_nettype none
`include "cache_settings.svh"

module tag_store (
    input  logic clk,
    tag_if.store tags
);

    // One row per set, one entry per way.
    cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] rows [`CACHE_LINES];
    cache_pkg::way_t victim_ptr [`CACHE_LINES];

    // Read side, registered from index.
    cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] row_q;
    mem_bus_pkg::tag_t tag_q;
    cache_pkg::way_t victim_q;

    always_ff @(posedge clk) begin
        row_q    <= rows[tags.index];
        tag_q    <= tags.lookup_tag;
        victim_q <= victim_ptr[tags.index];

        if (tags.wr_en) begin
            rows[tags.index][tags.wr_way] <= tags.wr_entry;
        end

        if (tags.advance_victim) begin
            victim_ptr[tags.index] <= victim_ptr[tags.index] + 1'b1;
        end else if (tags.wr_en && !tags.wr_entry.valid) begin
            // An emptied set starts its round robin over at way 0.
            victim_ptr[tags.index] <= '0;
        end
    end

    // Compare against every valid way at once.
    always_comb begin
        tags.hit     = 1'b0;
        tags.hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (row_q[w].valid && row_q[w].tag == tag_q) begin
                tags.hit     = 1'b1;
                tags.hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign tags.victim_way   = victim_q;
    assign tags.victim_entry = row_q[victim_q];

    // Flush scan looks at the way it is about to rewrite.
    assign tags.scan_entry   = row_q[tags.wr_way];

endmodule

`default_nettype wire

// ==== hdl/data_store.sv ====
// Byte-writable data RAM, one word array per way, read in all ways together.
`timescale 1ns/1ns
`default_nettype none
`include "cache_settings.svh"

module data_store (
    input  logic  clk,
    data_if.store data
);

    localparam int WORDS = `CACHE_LINES * `CACHE_LINE_WORDS;
    localparam int BYTES = `CACHE_DATA_BITS / 8;

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        mem_bus_pkg::word_t ram [WORDS];
        mem_bus_pkg::word_t rd_q;

        always_ff @(posedge clk) begin
            if (data.wr_en && data.wr_way == cache_pkg::way_t'(w)) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (data.wr_mask[b]) begin
                        ram[data.wr_addr][b*8 +: 8] <= data.wr_data[b*8 +: 8];
                    end
                end
            end
            rd_q <= ram[data.rd_addr];
        end

        assign data.way_data[w] = rd_q;
    end

endmodule

`default_nettype wire

// ==== hdl/cache_controller.sv ====
// Cache FSM for hits, write-back, refill, reset invalidation and flush.
`timescale 1ns/1ns
`default_nettype none
`include "cache_settings.svh"

module cache_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpu_re,
    input  mem_bus_pkg::byte_mask_t cpu_we,
    input  mem_bus_pkg::word_addr_t cpu_addr,
    input  mem_bus_pkg::word_t      cpu_wdata,
    input  logic                    flush,
    output logic                    cpu_ready,
    output mem_bus_pkg::word_t      cpu_rdata,
    output logic                    flushing,
    output logic                    mem_re,
    output logic                    mem_we,
    output mem_bus_pkg::word_addr_t mem_addr,
    output mem_bus_pkg::word_t      mem_wdata,
    input  logic                    mem_ready,
    input  mem_bus_pkg::word_t      mem_rdata,
    tag_if.ctrl                     tags,
    data_if.ctrl                    data
);

    cache_pkg::ctrl_state_t state;

    // Captured CPU request.
    mem_bus_pkg::addr_fields_t req;
    mem_bus_pkg::byte_mask_t   req_we;
    mem_bus_pkg::word_t        req_wdata;

    // Line transfer bookkeeping.
    cache_pkg::way_t           line_way;
    mem_bus_pkg::tag_t         wb_tag;
    mem_bus_pkg::set_index_t   wb_set;
    mem_bus_pkg::line_offset_t word_cnt;
    logic                      word_ready;
    logic                      line_done;

    // Set and way walk for init and flush.
    mem_bus_pkg::set_index_t   scan_set;
    cache_pkg::way_t           scan_way;
    logic                      scan_read;

    mem_bus_pkg::addr_fields_t cur;
    mem_bus_pkg::mem_op_t      mem_op;
    logic                      last_word;
    logic                      scan_last;
    logic                      scan_dirty;
    logic                      wb_state;

    // Stores are addressed from the CPU port while idle, from the request otherwise.
    assign cur = (state == cache_pkg::ST_IDLE) ?
                 mem_bus_pkg::addr_fields_t'(cpu_addr) : req;

    assign last_word  = word_cnt == mem_bus_pkg::line_offset_t'(`CACHE_LINE_WORDS - 1);
    assign scan_last  = scan_set == mem_bus_pkg::set_index_t'(`CACHE_LINES - 1) &&
                        scan_way == cache_pkg::way_t'(`CACHE_WAYS - 1);
    assign scan_dirty = tags.scan_entry.valid && tags.scan_entry.dirty;
    assign wb_state   = state inside {cache_pkg::ST_WRITEBACK, cache_pkg::ST_FLUSH_WB};
    assign flushing   = state inside {cache_pkg::ST_INIT, cache_pkg::ST_FLUSH_SCAN,
                                      cache_pkg::ST_FLUSH_WB};

    assign tags.index      = flushing ? scan_set : cur.set;
    assign tags.lookup_tag = cur.tag;
    assign tags.wr_way     = flushing ? scan_way :
                             (state == cache_pkg::ST_LOOKUP) ? tags.hit_way : line_way;

    assign data.rd_addr = wb_state ? mem_bus_pkg::line_addr_t'({wb_set, word_cnt}) :
                                     mem_bus_pkg::line_addr_t'({cur.set, cur.offset});

    // Hit writes take the CPU word, refill writes the memory word.
    assign data.wr_way  = (state == cache_pkg::ST_LOOKUP) ? tags.hit_way : line_way;
    assign data.wr_addr = mem_bus_pkg::line_addr_t'({req.set,
                          (state == cache_pkg::ST_LOOKUP) ? req.offset : word_cnt});
    assign data.wr_mask = (state == cache_pkg::ST_LOOKUP) ? req_we : '1;
    assign data.wr_data = (state == cache_pkg::ST_LOOKUP) ? req_wdata : mem_rdata;

    assign mem_re    = mem_op == mem_bus_pkg::MEM_READ;
    assign mem_we    = mem_op == mem_bus_pkg::MEM_WRITE;
    assign mem_addr  = (state == cache_pkg::ST_REFILL) ? {req.tag, req.set, word_cnt} :
                                                         {wb_tag, wb_set, word_cnt};
    assign mem_wdata = data.way_data[line_way];

    always_comb begin
        tags.wr_en          = 1'b0;
        tags.wr_entry       = '0;
        tags.advance_victim = 1'b0;
        data.wr_en          = 1'b0;
        mem_op              = mem_bus_pkg::MEM_IDLE;
        case (state)
            cache_pkg::ST_INIT: begin
                tags.wr_en = 1'b1;
            end
            cache_pkg::ST_LOOKUP: begin
                if (tags.hit && req_we != '0) begin
                    tags.wr_en    = 1'b1;
                    tags.wr_entry = '{valid: 1'b1, dirty: 1'b1, tag: req.tag};
                    data.wr_en    = 1'b1;
                end
            end
            cache_pkg::ST_WRITEBACK, cache_pkg::ST_FLUSH_WB: begin
                if (word_ready) begin
                    mem_op = mem_bus_pkg::MEM_WRITE;
                end
                // Flushed line is dropped once its last word is out.
                if (state == cache_pkg::ST_FLUSH_WB && word_ready && mem_ready && last_word) begin
                    tags.wr_en = 1'b1;
                end
            end
            cache_pkg::ST_REFILL: begin
                if (!line_done) begin
                    mem_op     = mem_bus_pkg::MEM_READ;
                    data.wr_en = mem_ready;
                    if (mem_ready && last_word) begin
                        tags.wr_en          = 1'b1;
                        tags.wr_entry       = '{valid: 1'b1, dirty: 1'b0, tag: req.tag};
                        tags.advance_victim = 1'b1;
                    end
                end
            end
            cache_pkg::ST_FLUSH_SCAN: begin
                tags.wr_en = scan_read && !scan_dirty;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        cpu_ready <= 1'b0;
        if (reset) begin
            state      <= cache_pkg::ST_INIT;
            scan_set   <= '0;
            scan_way   <= '0;
            scan_read  <= 1'b0;
            word_cnt   <= '0;
            word_ready <= 1'b0;
            line_done  <= 1'b0;
        end else begin
            case (state)
                cache_pkg::ST_INIT: begin
                    {scan_set, scan_way} <= {scan_set, scan_way} + 1'b1;
                    if (scan_last) begin
                        state <= cache_pkg::ST_IDLE;
                    end
                end
                cache_pkg::ST_IDLE: begin
                    // The cycle with cpu_ready still shows the finished request.
                    if (!cpu_ready && (cpu_re || cpu_we != '0)) begin
                        state <= cache_pkg::ST_LOOKUP;
                    end else if (!cpu_ready && flush) begin
                        scan_set  <= '0;
                        scan_way  <= '0;
                        scan_read <= 1'b0;
                        state     <= cache_pkg::ST_FLUSH_SCAN;
                    end
                end
                cache_pkg::ST_LOOKUP: begin
                    if (tags.hit) begin
                        cpu_ready <= 1'b1;
                        state     <= cache_pkg::ST_IDLE;
                    end else begin
                        line_way   <= tags.victim_way;
                        wb_tag     <= tags.victim_entry.tag;
                        wb_set     <= req.set;
                        word_cnt   <= '0;
                        word_ready <= 1'b0;
                        line_done  <= 1'b0;
                        if (tags.victim_entry.valid && tags.victim_entry.dirty) begin
                            state <= cache_pkg::ST_WRITEBACK;
                        end else begin
                            state <= cache_pkg::ST_REFILL;
                        end
                    end
                end
                cache_pkg::ST_WRITEBACK, cache_pkg::ST_FLUSH_WB: begin
                    // One cycle for the RAM read, then hold the word until accepted.
                    if (!word_ready) begin
                        word_ready <= 1'b1;
                    end else if (mem_ready) begin
                        word_ready <= 1'b0;
                        word_cnt   <= word_cnt + 1'b1;
                        if (last_word && state == cache_pkg::ST_WRITEBACK) begin
                            state <= cache_pkg::ST_REFILL;
                        end else if (last_word) begin
                            {scan_set, scan_way} <= {scan_set, scan_way} + 1'b1;
                            state <= scan_last ? cache_pkg::ST_IDLE : cache_pkg::ST_FLUSH_SCAN;
                        end
                    end
                end
                cache_pkg::ST_REFILL: begin
                    // Extra cycle lets the stores be re-read for the lookup.
                    if (line_done) begin
                        state <= cache_pkg::ST_LOOKUP;
                    end else if (mem_ready) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            line_done <= 1'b1;
                        end
                    end
                end
                cache_pkg::ST_FLUSH_SCAN: begin
                    if (!scan_read) begin
                        scan_read <= 1'b1;
                    end else begin
                        scan_read <= 1'b0;
                        if (scan_dirty) begin
                            line_way   <= scan_way;
                            wb_tag     <= tags.scan_entry.tag;
                            wb_set     <= scan_set;
                            word_cnt   <= '0;
                            word_ready <= 1'b0;
                            state      <= cache_pkg::ST_FLUSH_WB;
                        end else begin
                            {scan_set, scan_way} <= {scan_set, scan_way} + 1'b1;
                            if (scan_last) begin
                                state <= cache_pkg::ST_IDLE;
                            end
                        end
                    end
                end
                default: begin
                    state <= cache_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Request capture and read return.
    always_ff @(posedge clk) begin
        if (state == cache_pkg::ST_IDLE) begin
            req       <= mem_bus_pkg::addr_fields_t'(cpu_addr);
            req_we    <= cpu_we;
            req_wdata <= cpu_wdata;
        end
        if (state == cache_pkg::ST_LOOKUP) begin
            cpu_rdata <= data.way_data[tags.hit_way];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
// Two-way write-back cache top level joining the tag store, data store and FSM.
`timescale 1ns/1ns
`default_nettype none

module cache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpu_re,
    input  mem_bus_pkg::byte_mask_t cpu_we,
    input  mem_bus_pkg::word_addr_t cpu_addr,
    input  mem_bus_pkg::word_t      cpu_wdata,
    input  logic                    flush,
    output logic                    cpu_ready,
    output mem_bus_pkg::word_t      cpu_rdata,
    output logic                    flushing,
    output logic                    mem_re,
    output logic                    mem_we,
    output mem_bus_pkg::word_addr_t mem_addr,
    output mem_bus_pkg::word_t      mem_wdata,
    input  logic                    mem_ready,
    input  mem_bus_pkg::word_t      mem_rdata
);

    tag_if  tags ();
    data_if data ();

    tag_store i_tag_store (
        .clk  (clk),
        .tags (tags.store)
    );

    data_store i_data_store (
        .clk  (clk),
        .data (data.store)
    );

    cache_controller i_controller (
        .clk       (clk),
        .reset     (reset),
        .cpu_re    (cpu_re),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .flush     (flush),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .flushing  (flushing),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .tags      (tags.ctrl),
        .data      (data.ctrl)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and power-on reset source for the cache testbench.
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset held over the first four rising edges.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/cache_tb.sv ====
// Cache testbench with a memory model, file-driven CPU traffic and result checks.
`timescale 1ns/1ns
`default_nettype none
`include "cache_settings.svh"

module cache_tb;

    localparam int MEM_WORDS      = 1 << `CACHE_ADDR_BITS;
    localparam int REC_FIELDS     = 5;
    localparam int MAX_RECORDS    = 64;
    localparam int CYCLES_PER_REC = 200;

    // Operation codes in the first column of the stimulus file.
    localparam logic [31:0] KIND_READ     = 32'(mem_bus_pkg::MEM_READ);
    localparam logic [31:0] KIND_WRITE    = 32'(mem_bus_pkg::MEM_WRITE);
    localparam logic [31:0] KIND_FLUSH    = 32'h3;
    localparam logic [31:0] KIND_MEMCHECK = 32'h4;

    logic clk;
    logic reset;

    logic                    cpu_re;
    mem_bus_pkg::byte_mask_t cpu_we;
    mem_bus_pkg::word_addr_t cpu_addr;
    mem_bus_pkg::word_t      cpu_wdata;
    logic                    flush;
    logic                    cpu_ready;
    mem_bus_pkg::word_t      cpu_rdata;
    logic                    flushing;
    logic                    mem_re;
    logic                    mem_we;
    mem_bus_pkg::word_addr_t mem_addr;
    mem_bus_pkg::word_t      mem_wdata;
    logic                    mem_ready;
    mem_bus_pkg::word_t      mem_rdata;

    logic [31:0]        stimulus_words [MAX_RECORDS*REC_FIELDS];
    mem_bus_pkg::word_t mem_model [MEM_WORDS];
    int                 num_records;
    logic               records_loaded = 1'b0;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cache_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .cpu_re    (cpu_re),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .flush     (flush),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .flushing  (flushing),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: actual %h, expected %h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // One CPU request, held until cpu_ready; edges counts the wait.
    task automatic cpu_access(
        input  logic                    is_write,
        input  mem_bus_pkg::word_addr_t addr,
        input  mem_bus_pkg::word_t      wdata,
        input  mem_bus_pkg::byte_mask_t mask,
        output mem_bus_pkg::word_t      rdata,
        output int                      edges
    );
        @(posedge clk);
        cpu_re    <= !is_write;
        cpu_we    <= is_write ? mask : '0;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        edges = 0;
        @(negedge clk);
        while (!cpu_ready) begin
            edges++;
            @(negedge clk);
        end
        rdata = cpu_rdata;
        @(posedge clk);
        cpu_re <= 1'b0;
        cpu_we <= '0;
    endtask

    task automatic flush_cache();
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        while (!flushing) @(negedge clk);
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        while (flushing) @(negedge clk);
    endtask

    // Memory model with a random 1 to 3 cycle answer delay.
    initial begin
        logic [`CACHE_ADDR_BITS-1:0] req_addr;
        logic                        req_write;
        mem_bus_pkg::word_t          req_data;
        int                          delay;
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model[i] = 32'(i) ^ 32'h5a5a0000;
        end
        void'($urandom(32'h8a12));
        forever begin
            @(negedge clk);
            if (mem_re || mem_we) begin
                req_addr  = mem_addr;
                req_write = mem_we;
                req_data  = mem_wdata;
                delay     = 1 + int'($urandom % 3);
                repeat (delay) @(posedge clk);
                if (req_write) begin
                    mem_model[req_addr] = req_data;
                end else begin
                    mem_rdata <= mem_model[req_addr];
                end
                mem_ready <= 1'b1;
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    // Watchdog scaled by the number of file records.
    initial begin
        int limit;
        wait (records_loaded);
        limit = (num_records + 1) * CYCLES_PER_REC;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int                      base;
        int                      edges;
        logic [31:0]             kind;
        mem_bus_pkg::word_addr_t addr;
        mem_bus_pkg::word_t      wdata;
        mem_bus_pkg::byte_mask_t mask;
        mem_bus_pkg::word_t      expected;
        mem_bus_pkg::word_t      rdata;
        cpu_re    = 1'b0;
        cpu_we    = '0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        flush     = 1'b0;

        for (int i = 0; i < MAX_RECORDS*REC_FIELDS; i++) begin
            stimulus_words[i] = '0;
        end
        $readmemh("verification/cache_stimulus.txt", stimulus_words);
        num_records = 0;
        while (num_records < MAX_RECORDS && stimulus_words[num_records*REC_FIELDS] != 0) begin
            num_records++;
        end
        records_loaded = 1'b1;
        if (num_records == 0) begin
            $display("the stimulus file holds no records");
            $display("TEST FAILED");
            $fatal(1, "no stimulus");
        end

        // Tags are cleared right after reset, then flushing drops.
        do @(negedge clk); while (reset);
        check_value("flushing", 32'(flushing), 32'h1);
        while (flushing) @(negedge clk);

        for (int rec = 0; rec < num_records; rec++) begin
            base     = rec * REC_FIELDS;
            kind     = stimulus_words[base];
            addr     = stimulus_words[base + 1][`CACHE_ADDR_BITS-1:0];
            wdata    = stimulus_words[base + 2];
            mask     = stimulus_words[base + 3][`CACHE_DATA_BITS/8-1:0];
            expected = stimulus_words[base + 4];
            case (kind)
                KIND_READ: begin
                    cpu_access(1'b0, addr, '0, '0, rdata, edges);
                    check_value($sformatf("cpu_rdata at %h", addr), rdata, expected);
                    // A hit answers two edges after the request is driven.
                    if (mask != '0) begin
                        check_value("cpu_ready latency", 32'(edges), 32'h2);
                    end
                end
                KIND_WRITE: begin
                    cpu_access(1'b1, addr, wdata, mask, rdata, edges);
                end
                KIND_FLUSH: begin
                    flush_cache();
                end
                KIND_MEMCHECK: begin
                    check_value($sformatf("memory[%h]", addr), mem_model[addr], expected);
                end
                default: begin
                    $display("record %0d has an unknown operation code %h", rec, kind);
                    $display("TEST FAILED");
                    $fatal(1, "bad stimulus record");
                end
            endcase
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/cache_stimulus.txt ====
// Columns in hex: kind addr wdata mask expected. Kind 1 read, 2 write, 3 flush, 4 memcheck.
// A read with mask 1 must hit; a memcheck compares the memory model word with expected.

// Refill of untouched lines in several sets.
1 0000 00000000 0 5a5a0000
1 0125 00000000 0 5a5a0125
1 0a3a 00000000 0 5a5a0a3a
1 7f1f 00000000 0 5a5a7f1f

// Partial write hit, then read hits in the same line.
2 0002 deadbeef 5 00000000
1 0002 00000000 1 5aad00ef
1 0003 00000000 1 5a5a0003

// Two dirty lines in set 3, then a third line evicts them in turn.
2 000d 11223344 f 00000000
2 002e 55667788 3 00000000
1 004c 00000000 0 5a5a004c
4 000d 00000000 0 11223344
1 000d 00000000 0 11223344
1 002e 00000000 0 5a5a7788
1 002c 00000000 1 5a5a002c

// Dirty lines in sets 1, 5 and 6, then a full flush.
2 0125 a5a5a5a5 8 00000000
2 0a39 0f0f0f0f f 00000000
2 1234 cafef00d f 00000000
3 0000 00000000 0 00000000

// Memory after the flush.
4 0002 00000000 0 5aad00ef
4 0003 00000000 0 5a5a0003
4 0125 00000000 0 a55a0125
4 0a39 00000000 0 0f0f0f0f
4 1234 00000000 0 cafef00d

// Refill after the flush brings the written words back.
1 0125 00000000 0 a55a0125
1 1234 00000000 0 cafef00d
1 0002 00000000 0 5aad00ef
1 0003 00000000 1 5a5a0003

// ==== verilog.f ====
+incdir+hdl
hdl/mem_bus_pkg.sv
hdl/cache_pkg.sv
hdl/cache_ifs.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/cache_controller.sv
hdl/cache_top.sv
verification/tb_clock_gen.sv
verification/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module cache_tb \
    -Mdir "$BUILD_DIR" -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/cache_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
